// File: rtl/mul_cfg.svh
`ifndef MUL_CFG_SVH
`define MUL_CFG_SVH

// Request FIFO depth, power of two, at least 2
`define MUL_REQ_DEPTH 4

// Result queue depth, power of two
`define MUL_RES_DEPTH 4

// APB register offsets
`define MUL_REG_RS1    8'h00
`define MUL_REG_RS2    8'h04
`define MUL_REG_CMD    8'h08
`define MUL_REG_RESULT 8'h0C
`define MUL_REG_STATUS 8'h10

`endif

// File: rtl/mul_pkg.sv
package mul_pkg;

  // Multiply opcode, codes follow funct3[1:0] of the M extension
  // MUL_LO  -> MUL, lower word
  // MUL_HSS -> MULH, signed x signed
  // MUL_HSU -> MULHSU, signed x unsigned
  // MUL_HUU -> MULHU, unsigned x unsigned
  typedef enum logic [1:0] {
    MUL_LO  = 2'd0,
    MUL_HSS = 2'd1,
    MUL_HSU = 2'd2,
    MUL_HUU = 2'd3
  } mul_op_e;

  // One queued request, 66 bits
  // Op sits in the top bits so a raw dump reads op first
  typedef struct packed {
    mul_op_e     op;
    logic [31:0] rs1;
    logic [31:0] rs2;
  } mul_req_t;

endpackage

// File: rtl/mul_req_if.sv
// Request stream between register block, FIFO and multiplier
// Transfer happens on a clock edge with valid and ready both high
interface mul_req_if;
  import mul_pkg::*;

  // Handshake
  logic        valid;
  logic        ready;

  // Payload, held while valid is high and ready is low
  mul_op_e     op;
  logic [31:0] rs1;
  logic [31:0] rs2;

  // Producer side drives valid and payload
  modport src (
    output valid,
    output op,
    output rs1,
    output rs2,
    input  ready
  );

  // Consumer side returns ready
  modport snk (
    input  valid,
    input  op,
    input  rs1,
    input  rs2,
    output ready
  );

endinterface

// File: rtl/mul_wb_correct.sv
module mul_wb_correct (
  input  logic [63:0]     product,
  input  logic [31:0]     rs1_data,
  input  logic [31:0]     rs2_data,
  input  mul_pkg::mul_op_e op,
  output logic [31:0]     result
);
  import mul_pkg::*;

  logic        rs1_signed;
  logic        rs2_signed;
  logic [31:0] corr_rs1;
  logic [31:0] corr_rs2;
  logic [31:0] upper_fixed;

  // MULH and MULHSU treat rs1 as signed, only MULH treats rs2 as signed
  assign rs1_signed = (op == MUL_HSS) || (op == MUL_HSU);
  assign rs2_signed = (op == MUL_HSS);

  // A negative signed operand adds 2^32 times the other operand
  // to the unsigned product, so take that back out of the upper word
  assign corr_rs1 = (rs1_signed && rs1_data[31]) ? rs2_data : 32'h0;
  assign corr_rs2 = (rs2_signed && rs2_data[31]) ? rs1_data : 32'h0;

  assign upper_fixed = product[63:32] - corr_rs1 - corr_rs2;

  // Lower word needs no fix, it is the same for every signedness
  always_comb begin
    case (op)
      MUL_LO:  result = product[31:0];
      default: result = upper_fixed;
    endcase
  end

endmodule

// File: rtl/mul_pipe.sv
module mul_pipe (
  input  logic        clk,
  input  logic        rst_n,
  mul_req_if.snk      req,
  output logic        res_valid,
  input  logic        res_ready,
  output logic [31:0] res_data
);
  import mul_pkg::*;

  // Stage 1, operands as accepted
  logic        s1_valid;
  mul_op_e     s1_op;
  logic [31:0] s1_rs1;
  logic [31:0] s1_rs2;
  logic        s1_ready;

  // Stage 2, raw unsigned product plus what the correction needs
  logic        s2_valid;
  logic [63:0] s2_product;
  mul_op_e     s2_op;
  logic [31:0] s2_rs1;
  logic [31:0] s2_rs2;
  logic        s2_ready;

  // Stall chain, a stage moves when the next one is empty or moving
  assign s2_ready  = !s2_valid || res_ready;
  assign s1_ready  = !s1_valid || s2_ready;
  assign req.ready = s1_ready;
  assign res_valid = s2_valid;

  // Stage valid bits
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      if (s1_ready) begin
        s1_valid <= req.valid;
      end
      if (s2_ready) begin
        s2_valid <= s1_valid;
      end
    end
  end

  // Stage payloads, loaded only on a real transfer
  always_ff @(posedge clk) begin
    if (req.valid && s1_ready) begin
      s1_op  <= req.op;
      s1_rs1 <= req.rs1;
      s1_rs2 <= req.rs2;
    end
    if (s1_valid && s2_ready) begin
      // Full 32x32 unsigned product, signs fixed up after the register
      s2_product <= {32'h0, s1_rs1} * {32'h0, s1_rs2};
      s2_op      <= s1_op;
      s2_rs1     <= s1_rs1;
      s2_rs2     <= s1_rs2;
    end
  end

  // Writeback correction straight off stage 2
  mul_wb_correct u_wb (
    .product  (s2_product),
    .rs1_data (s2_rs1),
    .rs2_data (s2_rs2),
    .op       (s2_op),
    .result   (res_data)
  );

endmodule

// File: rtl/mul_req_fifo.sv
`include "mul_cfg.svh"

module mul_req_fifo (
  input  logic   clk,
  input  logic   rst_n,
  mul_req_if.snk push,
  mul_req_if.src pop
);
  import mul_pkg::*;

  localparam int DEPTH = `MUL_REQ_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  mul_req_t         mem [DEPTH];
  mul_req_t         head;
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             full;
  logic             empty;
  logic             do_push;
  logic             do_pop;

  assign full  = (count == CNT_W'(DEPTH));
  assign empty = (count == '0);

  // A full FIFO still takes a push when the head leaves in the same cycle
  assign push.ready = !full || pop.ready;
  assign do_push    = push.valid && push.ready;
  assign do_pop     = pop.valid && pop.ready;

  // Head entry goes straight out, registered storage
  assign head      = mem[rd_ptr];
  assign pop.valid = !empty;
  assign pop.op    = head.op;
  assign pop.rs1   = head.rs1;
  assign pop.rs2   = head.rs2;

  // Pointers wrap naturally with power-of-two depth
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Entry storage
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= '{op: push.op, rs1: push.rs1, rs2: push.rs2};
    end
  end

endmodule

// File: rtl/mul_apb_regs.sv
`include "mul_cfg.svh"

module mul_apb_regs (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [7:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pslverr,
  input  logic        res_valid,
  input  logic [31:0] res_data,
  output logic        res_ready,
  mul_req_if.src      req
);
  import mul_pkg::*;

  localparam int RES_DEPTH = `MUL_RES_DEPTH;
  // Depth of 1 still needs a one-bit pointer
  localparam int RES_PTR_W = (RES_DEPTH > 1) ? $clog2(RES_DEPTH) : 1;
  localparam int RES_CNT_W = $clog2(RES_DEPTH + 1);

  logic                 access;
  logic                 rs1_wr;
  logic                 rs2_wr;
  logic                 cmd_wr;
  logic                 result_rd;
  logic                 fifo_full;
  logic [31:0]          rs1_q;
  logic [31:0]          rs2_q;
  logic [31:0]          status;

  // Result queue storage and bookkeeping
  logic [31:0]          res_mem [RES_DEPTH];
  logic [RES_PTR_W-1:0] res_wr_ptr;
  logic [RES_PTR_W-1:0] res_rd_ptr;
  logic [RES_CNT_W-1:0] res_count;
  logic                 res_empty;
  logic                 res_full;
  logic                 res_push;
  logic                 res_pop;

  // APB access phase, all side effects happen here
  assign access    = psel && penable;
  assign rs1_wr    = access && pwrite && (paddr == `MUL_REG_RS1);
  assign rs2_wr    = access && pwrite && (paddr == `MUL_REG_RS2);
  assign cmd_wr    = access && pwrite && (paddr == `MUL_REG_CMD);
  assign result_rd = access && !pwrite && (paddr == `MUL_REG_RESULT);

  // CMD write becomes a single-cycle request with the current operands
  assign req.valid = cmd_wr;
  assign req.op    = mul_op_e'(pwdata[1:0]);
  assign req.rs1   = rs1_q;
  assign req.rs2   = rs2_q;
  assign fifo_full = !req.ready;

  // Operand registers
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rs1_q <= '0;
      rs2_q <= '0;
    end else begin
      if (rs1_wr) begin
        rs1_q <= pwdata;
      end
      if (rs2_wr) begin
        rs2_q <= pwdata;
      end
    end
  end

  assign res_empty = (res_count == '0);
  assign res_full  = (res_count == RES_CNT_W'(RES_DEPTH));
  assign res_ready = !res_full;
  assign res_push  = res_valid && res_ready;
  // Pop only when something is there, empty read is an error instead
  assign res_pop   = result_rd && !res_empty;

  // Result queue pointers and count
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      res_wr_ptr <= '0;
      res_rd_ptr <= '0;
      res_count  <= '0;
    end else begin
      if (res_push) begin
        res_wr_ptr <= (res_wr_ptr == RES_PTR_W'(RES_DEPTH - 1)) ? '0 : res_wr_ptr + 1'b1;
      end
      if (res_pop) begin
        res_rd_ptr <= (res_rd_ptr == RES_PTR_W'(RES_DEPTH - 1)) ? '0 : res_rd_ptr + 1'b1;
      end
      case ({res_push, res_pop})
        2'b10:   res_count <= res_count + 1'b1;
        2'b01:   res_count <= res_count - 1'b1;
        default: res_count <= res_count;
      endcase
    end
  end

  // Result storage
  always_ff @(posedge clk) begin
    if (res_push) begin
      res_mem[res_wr_ptr] <= res_data;
    end
  end

  // Status layout: count in 15:8, queue empty in bit 1, FIFO full in bit 0
  assign status = {16'h0, 8'(res_count), 6'h0, res_empty, fifo_full};

  // Read mux, driven whenever a read is selected
  always_comb begin
    prdata = '0;
    if (psel && !pwrite) begin
      case (paddr)
        `MUL_REG_RS1:    prdata = rs1_q;
        `MUL_REG_RS2:    prdata = rs2_q;
        `MUL_REG_RESULT: prdata = res_empty ? 32'h0 : res_mem[res_rd_ptr];
        `MUL_REG_STATUS: prdata = status;
        default:         prdata = '0;
      endcase
    end
  end

  // Error on a dropped command or a read from an empty queue
  assign pslverr = (cmd_wr && fifo_full) || (result_rd && res_empty);

endmodule

// File: rtl/mul_top.sv
module mul_top (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [7:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pslverr
);

  // Result path from the multiplier back to the register block
  logic        res_valid;
  logic        res_ready;
  logic [31:0] res_data;

  // Register block to FIFO
  mul_req_if cmd_req ();

  // FIFO to multiplier
  mul_req_if pipe_req ();

  // APB registers and result queue
  mul_apb_regs u_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pslverr   (pslverr),
    .res_valid (res_valid),
    .res_data  (res_data),
    .res_ready (res_ready),
    .req       (cmd_req.src)
  );

  // Request buffer
  mul_req_fifo u_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .push  (cmd_req.snk),
    .pop   (pipe_req.src)
  );

  // Two-stage multiplier with writeback fixup
  mul_pipe u_pipe (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (pipe_req.snk),
    .res_valid (res_valid),
    .res_ready (res_ready),
    .res_data  (res_data)
  );

endmodule

// File: tests/tb_mul_tasks.svh
`ifndef TB_MUL_TASKS_SVH
`define TB_MUL_TASKS_SVH

// One APB write, setup then access, then back to idle
task automatic write_reg(input logic [7:0] addr, input logic [31:0] data, output logic err);
  @(negedge clk);
  psel    = 1'b1;
  penable = 1'b0;
  pwrite  = 1'b1;
  paddr   = addr;
  pwdata  = data;
  @(negedge clk);
  penable = 1'b1;
  // pslverr settles during the low phase of the access cycle
  #(CLK_PERIOD / 4);
  err = pslverr;
  @(negedge clk);
  psel    = 1'b0;
  penable = 1'b0;
endtask

// One APB read, data sampled before the edge that commits the access
task automatic read_reg(input logic [7:0] addr, output logic [31:0] data, output logic err);
  @(negedge clk);
  psel    = 1'b1;
  penable = 1'b0;
  pwrite  = 1'b0;
  paddr   = addr;
  @(negedge clk);
  penable = 1'b1;
  #(CLK_PERIOD / 4);
  data = prdata;
  err  = pslverr;
  @(negedge clk);
  psel    = 1'b0;
  penable = 1'b0;
endtask

// Poll STATUS until the masked bits match, bounded by POLL_LIMIT
task automatic wait_status(input logic [31:0] mask, input logic [31:0] value, input string what);
  logic [31:0] st;
  logic        err;
  int          polls;
  polls = 0;
  read_reg(`MUL_REG_STATUS, st, err);
  while (((st & mask) !== value) && (polls < POLL_LIMIT)) begin
    polls++;
    read_reg(`MUL_REG_STATUS, st, err);
  end
  if ((st & mask) !== value) begin
    $display("timeout after %0d status polls while waiting for %s", polls, what);
    $display("Simulation FAILED");
    $fatal(1, "status poll timed out");
  end
endtask

// Compare one value against its expected value
task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
  if (expected !== actual) begin
    $display("error: %s expected 0x%08h actual 0x%08h", name, expected, actual);
    $display("Simulation FAILED");
    $fatal(1, "value mismatch in %s", name);
  end
endtask

`endif

// File: tests/tb_mul_top.sv
`include "mul_cfg.svh"

module tb_mul_top;

  localparam int CLK_PERIOD = 8;
  localparam int POLL_LIMIT = 200;
  localparam int N_PAIRS    = 200;
  // Enough commands to fill the FIFO, both pipeline stages and the result queue
  localparam int N_FILL     = `MUL_REQ_DEPTH + `MUL_RES_DEPTH + 2;

  logic        clk;
  logic        rst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pslverr;

  integer      seed;
  // Expected results in CMD order
  logic [31:0] expect_q [$];
  logic [31:0] corners [5];

  mul_top dut0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pslverr (pslverr)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  `include "tb_mul_tasks.svh"

  // Reference product from full 64-bit signed and unsigned arithmetic
  function automatic logic [31:0] model_result(input logic [1:0] op, input logic [31:0] a,
                                               input logic [31:0] b);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic signed [63:0] ub;
    logic [63:0]        prod;
    sa = {{32{a[31]}}, a};
    sb = {{32{b[31]}}, b};
    ub = {32'h0, b};
    case (op)
      2'd1:    prod = sa * sb;
      2'd2:    prod = sa * ub;
      default: prod = {32'h0, a} * {32'h0, b};
    endcase
    if (op == 2'd0) begin
      return prod[31:0];
    end else begin
      return prod[63:32];
    end
  endfunction

  // Roughly one draw in four is a corner value
  task automatic pick_operand(output logic [31:0] v);
    logic [31:0] r;
    r = $random(seed);
    if (r[1:0] == 2'b00) begin
      v = corners[r[10:8] % 5];
    end else begin
      v = $random(seed);
    end
  endtask

  // Load operands, write CMD, queue the expected result if accepted
  task automatic issue_cmd(input logic [1:0] op, input logic [31:0] a, input logic [31:0] b,
                           output logic err);
    logic e;
    write_reg(`MUL_REG_RS1, a, e);
    check_value("rs1_write_pslverr", 32'h0, 32'(e));
    write_reg(`MUL_REG_RS2, b, e);
    check_value("rs2_write_pslverr", 32'h0, 32'(e));
    write_reg(`MUL_REG_CMD, {30'h0, op}, err);
    if (!err) begin
      expect_q.push_back(model_result(op, a, b));
    end
  endtask

  initial begin : main
    logic [31:0] rd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] v;
    logic        err;
    int          op;
    seed      = 37731;
    corners   = '{32'h0000_0000, 32'h0000_0001, 32'h7FFF_FFFF, 32'h8000_0000, 32'hFFFF_FFFF};
    clk       = 1'b0;
    rst_n     = 1'b0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Reset state
    check_value("reset_pslverr", 32'h0, 32'(pslverr));
    read_reg(`MUL_REG_STATUS, rd, err);
    check_value("reset_status", 32'h0000_0002, rd);
    read_reg(`MUL_REG_RS1, rd, err);
    check_value("reset_rs1", 32'h0, rd);
    read_reg(`MUL_REG_RS2, rd, err);
    check_value("reset_rs2", 32'h0, rd);
    check_value("reset_read_pslverr", 32'h0, 32'(err));

    // Operand register readback
    repeat (8) begin
      v = $random(seed);
      write_reg(`MUL_REG_RS1, v, err);
      read_reg(`MUL_REG_RS1, rd, err);
      check_value("rs1_readback", v, rd);
      v = $random(seed);
      write_reg(`MUL_REG_RS2, v, err);
      read_reg(`MUL_REG_RS2, rd, err);
      check_value("rs2_readback", v, rd);
    end

    // One command at a time for every opcode
    for (op = 0; op < 4; op++) begin
      for (int i = 0; i < N_PAIRS; i++) begin
        pick_operand(a);
        pick_operand(b);
        issue_cmd(op[1:0], a, b, err);
        check_value($sformatf("op%0d_cmd%0d_pslverr", op, i), 32'h0, 32'(err));
        wait_status(32'h2, 32'h0, "a result");
        read_reg(`MUL_REG_RESULT, rd, err);
        check_value($sformatf("op%0d_pair%0d", op, i), expect_q.pop_front(), rd);
      end
    end

    // Fill everything without reading, then one more command must be dropped
    for (int i = 0; i < N_FILL; i++) begin
      pick_operand(a);
      pick_operand(b);
      v = $random(seed);
      issue_cmd(v[1:0], a, b, err);
      check_value($sformatf("fill_cmd%0d_pslverr", i), 32'h0, 32'(err));
    end
    wait_status(32'h0000_FF01, (32'(`MUL_RES_DEPTH) << 8) | 32'h1, "full queues");
    write_reg(`MUL_REG_CMD, 32'h0, err);
    check_value("overflow_cmd_pslverr", 32'h1, 32'(err));
    for (int i = 0; i < N_FILL; i++) begin
      wait_status(32'h2, 32'h0, "a drained result");
      read_reg(`MUL_REG_RESULT, rd, err);
      check_value($sformatf("drain%0d", i), expect_q.pop_front(), rd);
    end
    check_value("drain_leftover", 32'h0, 32'(expect_q.size()));
    read_reg(`MUL_REG_STATUS, rd, err);
    check_value("drain_status", 32'h0000_0002, rd);

    // Empty result read, then normal traffic again
    read_reg(`MUL_REG_RESULT, rd, err);
    check_value("empty_read_data", 32'h0, rd);
    check_value("empty_read_pslverr", 32'h1, 32'(err));
    for (op = 0; op < 4; op++) begin
      pick_operand(a);
      pick_operand(b);
      issue_cmd(op[1:0], a, b, err);
      check_value($sformatf("after_empty_cmd%0d_pslverr", op), 32'h0, 32'(err));
      wait_status(32'h2, 32'h0, "a result after the empty read");
      read_reg(`MUL_REG_RESULT, rd, err);
      check_value($sformatf("after_empty_op%0d", op), expect_q.pop_front(), rd);
      check_value($sformatf("after_empty_read%0d_pslverr", op), 32'h0, 32'(err));
    end

    $display("Simulation PASSED");
    $finish;
  end

endmodule

// File: flist.f
+incdir+rtl
+incdir+tests
rtl/mul_pkg.sv
rtl/mul_req_if.sv
rtl/mul_wb_correct.sv
rtl/mul_pipe.sv
rtl/mul_req_fifo.sv
rtl/mul_apb_regs.sv
rtl/mul_top.sv
tests/tb_mul_top.sv
